// File: spmv_vector_loader.f
src/vec_loader_pkg.sv
src/vec_addr_decoder.sv
src/vec_beat_splitter.sv
src/vec_read_gather.sv
src/spmv_vector_loader.sv
testbench/vec_mem_model.sv
testbench/tb_spmv_vector_loader.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= spmv_vector_loader.f
TB_TOP    ?= tb_spmv_vector_loader
RTL_TOP   ?= spmv_vector_loader
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

RTL_FILES := $(shell grep '^src/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_spmv_vector_loader.sv
module tb_spmv_vector_loader;

    localparam int HW           = vec_loader_pkg::HOST_DATA_W;
    localparam int HBM_W        = vec_loader_pkg::HBM_DATA_W;
    localparam int BRAM_W       = vec_loader_pkg::BRAM_DATA_W;
    localparam int ADDR_W       = vec_loader_pkg::ADDR_W;
    localparam int SW           = vec_loader_pkg::HOST_STRB_W;
    localparam int N_RANDOM     = 300;
    localparam int N_DIRECTED   = 12;
    localparam int RESET_CYCLES = 10;
    localparam int LIMIT        = (N_RANDOM + N_DIRECTED) * 80 + RESET_CYCLES;
    localparam logic [ADDR_W-1:0] HBM_BASE  = vec_loader_pkg::HBM_BASE_DEF;
    localparam logic [ADDR_W-1:0] HBM_SIZE  = vec_loader_pkg::HBM_SIZE_DEF;
    localparam logic [ADDR_W-1:0] BRAM_BASE = vec_loader_pkg::BRAM_BASE_DEF;
    localparam logic [ADDR_W-1:0] BRAM_SIZE = vec_loader_pkg::BRAM_SIZE_DEF;

    logic                    pcie_aclk;
    logic                    rst;
    logic                    req_valid;
    logic                    req_ready;
    vec_loader_pkg::op_e     req_op;
    logic [ADDR_W-1:0]       req_addr;
    logic [HW-1:0]           req_wdata;
    logic [SW-1:0]           req_wstrb;
    logic                    rsp_valid;
    logic                    rsp_ready;
    vec_loader_pkg::op_e     rsp_op;
    logic [HW-1:0]           rsp_rdata;
    logic                    rsp_err;
    logic                    hbm_cmd_valid;
    logic                    hbm_cmd_ready;
    logic                    hbm_cmd_we;
    logic                    hbm_rvalid;
    logic [ADDR_W-1:0]       hbm_cmd_addr;
    logic [HBM_W-1:0]        hbm_cmd_wdata;
    logic [HBM_W-1:0]        hbm_rdata;
    logic [HBM_W/8-1:0]      hbm_cmd_wstrb;
    logic                    bram_cmd_valid;
    logic                    bram_cmd_ready;
    logic                    bram_cmd_we;
    logic                    bram_rvalid;
    logic [ADDR_W-1:0]       bram_cmd_addr;
    logic [BRAM_W-1:0]       bram_cmd_wdata;
    logic [BRAM_W-1:0]       bram_rdata;
    logic [BRAM_W/8-1:0]     bram_cmd_wstrb;

    logic [7:0]    ref_mem [longint];  // reference memory, one entry per written byte
    logic [31:0]   rng;
    logic [ADDR_W-1:0] cur_addr;       // request being checked at the beat ports
    logic [HW-1:0] cur_wdata;
    logic [SW-1:0] cur_wstrb;
    logic          cur_we;
    int            hbm_cnt;
    int            bram_cnt;
    int            errors;
    int            passed;
    int            failed;
    int            test_err;
    int            cycles;

    spmv_vector_loader #(
        .HBM_BASE(HBM_BASE), .HBM_SIZE(HBM_SIZE), .BRAM_BASE(BRAM_BASE), .BRAM_SIZE(BRAM_SIZE)
    ) dut_i (.*);

    vec_mem_model #(.BEAT_W(HBM_W), .ADDR_W(ADDR_W), .SEED(32'd18441 ^ 32'h5a5a)) hbm_mem_i (
        .pcie_aclk, .rst, .cmd_valid(hbm_cmd_valid), .cmd_ready(hbm_cmd_ready),
        .cmd_we(hbm_cmd_we), .cmd_addr(hbm_cmd_addr), .cmd_wdata(hbm_cmd_wdata),
        .cmd_wstrb(hbm_cmd_wstrb), .rvalid(hbm_rvalid), .rdata(hbm_rdata)
    );

    vec_mem_model #(.BEAT_W(BRAM_W), .ADDR_W(ADDR_W), .SEED(32'd18441 ^ 32'ha5a5)) bram_mem_i (
        .pcie_aclk, .rst, .cmd_valid(bram_cmd_valid), .cmd_ready(bram_cmd_ready),
        .cmd_we(bram_cmd_we), .cmd_addr(bram_cmd_addr), .cmd_wdata(bram_cmd_wdata),
        .cmd_wstrb(bram_cmd_wstrb), .rvalid(bram_rvalid), .rdata(bram_rdata)
    );

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic logic [HW-1:0] rand_word();
        logic [HW-1:0] w;
        for (int i = 0; i < HW / 32; i++) w[32*i +: 32] = next_rand();
        return w;
    endfunction

    // pick a line in the hbm window, the bram window or the gap between them
    function automatic logic [ADDR_W-1:0] rand_addr();
        logic [ADDR_W-1:0] line;
        logic [31:0]       sel;
        sel  = next_rand() % 3;
        line = ADDR_W'(next_rand() % 16) << 6;
        if (sel == 0) return HBM_BASE + line;
        else if (sel == 1) return BRAM_BASE + line;
        else return HBM_BASE + HBM_SIZE + line;
    endfunction

    task automatic check_word(input string name, input logic [HW-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_strb(input string name, input logic [SW-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input vec_loader_pkg::op_e got, exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_beats(input string name, input int got, exp);
        if (got != exp) begin
            errors++;
            $display("** Error: %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    // beat port monitor, address, direction and lsb-first slice of each accepted beat
    always @(posedge pcie_aclk) begin
        if (!rst && hbm_cmd_valid && hbm_cmd_ready) begin
            check_addr("hbm_cmd_addr", hbm_cmd_addr, cur_addr + ADDR_W'(hbm_cnt * HBM_W / 8));
            check_flag("hbm_cmd_we", hbm_cmd_we, cur_we);
            if (hbm_cmd_we) begin
                check_word("hbm_cmd_wdata", HW'(hbm_cmd_wdata),
                           HW'(cur_wdata[hbm_cnt*HBM_W +: HBM_W]));
                check_strb("hbm_cmd_wstrb", SW'(hbm_cmd_wstrb),
                           SW'(cur_wstrb[hbm_cnt*HBM_W/8 +: HBM_W/8]));
            end
            hbm_cnt++;
        end
        if (!rst && bram_cmd_valid && bram_cmd_ready) begin
            check_addr("bram_cmd_addr", bram_cmd_addr, cur_addr + ADDR_W'(bram_cnt * BRAM_W / 8));
            check_flag("bram_cmd_we", bram_cmd_we, cur_we);
            if (bram_cmd_we) begin
                check_word("bram_cmd_wdata", HW'(bram_cmd_wdata),
                           HW'(cur_wdata[bram_cnt*BRAM_W +: BRAM_W]));
                check_strb("bram_cmd_wstrb", SW'(bram_cmd_wstrb),
                           SW'(cur_wstrb[bram_cnt*BRAM_W/8 +: BRAM_W/8]));
            end
            bram_cnt++;
        end
    end

    // one host request, with its response checked against the reference model
    task automatic do_request(input vec_loader_pkg::op_e op, input logic [ADDR_W-1:0] addr,
                              input logic [HW-1:0] data, input logic [SW-1:0] strb);
        logic [HW-1:0] exp_data;
        logic          exp_err;
        int            exp_hbm;
        int            exp_bram;
        int            stall;
        longint        a;
        exp_hbm  = (addr >= HBM_BASE && addr < HBM_BASE + HBM_SIZE) ? HW / HBM_W : 0;
        exp_bram = (addr >= BRAM_BASE && addr < BRAM_BASE + BRAM_SIZE) ? HW / BRAM_W : 0;
        exp_err  = (exp_hbm == 0) && (exp_bram == 0);
        exp_data = '0;
        for (int b = 0; b < SW; b++) begin
            a = longint'(addr) + b;
            if (!exp_err && op == vec_loader_pkg::OP_READ && ref_mem.exists(a))
                exp_data[8*b +: 8] = ref_mem[a];
            if (!exp_err && op == vec_loader_pkg::OP_WRITE && strb[b])
                ref_mem[a] = data[8*b +: 8];
        end
        cur_addr  = addr;
        cur_wdata = data;
        cur_wstrb = strb;
        cur_we    = (op == vec_loader_pkg::OP_WRITE);
        hbm_cnt   = 0;
        bram_cnt  = 0;
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        req_wdata <= data;
        req_wstrb <= strb;
        @(posedge pcie_aclk);
        while (!(req_valid && req_ready)) @(posedge pcie_aclk);
        req_valid <= 1'b0;
        while (!rsp_valid) begin
            @(posedge pcie_aclk);
            check_flag("req_ready", req_ready, 1'b0);  // one request in flight
        end
        stall = int'(next_rand() % 4);  // host back-pressure
        repeat (stall) @(posedge pcie_aclk);
        rsp_ready <= 1'b1;
        @(posedge pcie_aclk);
        rsp_ready <= 1'b0;
        check_op("rsp_op", rsp_op, op);
        check_flag("rsp_err", rsp_err, exp_err);
        check_word("rsp_rdata", rsp_rdata, exp_data);
        check_beats("hbm beat count", hbm_cnt, exp_hbm);
        check_beats("bram beat count", bram_cnt, exp_bram);
    endtask

    task automatic end_test(input string name);
        if (errors == test_err) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: FAIL (%0d errors)", name, errors - test_err);
        end
        test_err = errors;
    endtask

    initial begin
        pcie_aclk = 1'b0;
        forever #2 pcie_aclk = ~pcie_aclk;
    end

    always @(posedge pcie_aclk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run still busy after %0d cycles", LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [HW-1:0] w;
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = vec_loader_pkg::OP_READ;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        rsp_ready = 1'b0;
        rng = 32'd18441;
        errors = 0;
        passed = 0;
        failed = 0;
        test_err = 0;
        cycles = 0;
        repeat (RESET_CYCLES) @(posedge pcie_aclk);
        rst <= 1'b0;
        @(posedge pcie_aclk);

        w = rand_word();  // hbm write then read back
        do_request(vec_loader_pkg::OP_WRITE, HBM_BASE + 'h40, w, '1);
        do_request(vec_loader_pkg::OP_READ, HBM_BASE + 'h40, '0, '0);
        end_test("hbm write/read");

        do_request(vec_loader_pkg::OP_WRITE, BRAM_BASE + 'h80, rand_word(), '1);
        do_request(vec_loader_pkg::OP_WRITE, BRAM_BASE + 'h80, rand_word(),
                   {next_rand(), next_rand()});  // partial merge
        do_request(vec_loader_pkg::OP_READ, BRAM_BASE + 'h80, '0, '0);
        end_test("bram partial strobes");

        do_request(vec_loader_pkg::OP_WRITE, HBM_BASE + HBM_SIZE, rand_word(), '1);
        do_request(vec_loader_pkg::OP_READ, BRAM_BASE + BRAM_SIZE + 'h40, '0, '0);
        end_test("unmapped address");

        do_request(vec_loader_pkg::OP_WRITE, HBM_BASE + 'h100, rand_word(), '1);
        do_request(vec_loader_pkg::OP_READ, HBM_BASE + 'h100, '0, '0);
        do_request(vec_loader_pkg::OP_WRITE, BRAM_BASE + 'h100, rand_word(), '1);
        do_request(vec_loader_pkg::OP_READ, BRAM_BASE + 'h100, '0, '0);
        end_test("beat split");

        for (int i = 0; i < N_RANDOM; i++) begin
            do_request(next_rand() % 2 ? vec_loader_pkg::OP_WRITE : vec_loader_pkg::OP_READ,
                       rand_addr(), rand_word(),
                       next_rand() % 4 == 0 ? '1 : {next_rand(), next_rand()});
        end
        end_test("random mixed");

        $display("summary: %0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/vec_mem_model.sv
module vec_mem_model #(
    parameter int          BEAT_W = 256,
    parameter int          ADDR_W = 48,
    parameter logic [31:0] SEED   = 32'd1
) (
    input  logic                pcie_aclk,
    input  logic                rst,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  logic                cmd_we,
    input  logic [ADDR_W-1:0]   cmd_addr,
    input  logic [BEAT_W-1:0]   cmd_wdata,
    input  logic [BEAT_W/8-1:0] cmd_wstrb,
    output logic                rvalid,
    output logic [BEAT_W-1:0]   rdata
);

    logic [7:0]        mem [longint];  // byte addressed, unwritten bytes read as zero
    logic [BEAT_W-1:0] rd_q [$];       // read beats waiting to return, in order
    int                due_q [$];      // cycle each queued beat is due
    logic [31:0]       rng = SEED;
    logic [BEAT_W-1:0] beat;
    int                cyc;
    int                stall;
    int                last_due;
    int                due;
    longint            a;

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    initial begin
        cmd_ready = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
    end

    always @(posedge pcie_aclk) begin
        if (rst) begin
            cmd_ready <= 1'b0;
            rvalid    <= 1'b0;
            rdata     <= '0;
            cyc = 0;
            stall = 0;
            last_due = 0;
            rd_q.delete();
            due_q.delete();
        end else begin
            cyc = cyc + 1;
            if (cmd_valid && cmd_ready) begin
                for (int b = 0; b < BEAT_W / 8; b++) begin
                    a = longint'(cmd_addr) + b;
                    if (cmd_we && cmd_wstrb[b]) mem[a] = cmd_wdata[8*b +: 8];
                    beat[8*b +: 8] = mem.exists(a) ? mem[a] : 8'h00;
                end
                if (!cmd_we) begin
                    due = cyc + 1 + int'(next_rand() % 6);  // latency 1 to 6
                    if (due <= last_due) due = last_due + 1;  // keep returns in order
                    last_due = due;
                    rd_q.push_back(beat);
                    due_q.push_back(due);
                end
                stall = int'(next_rand() % 4);  // 0 to 3 stall cycles
            end
            cmd_ready <= (stall == 0);
            if (stall > 0) stall = stall - 1;
            rvalid <= 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                rvalid <= 1'b1;
                rdata  <= rd_q.pop_front();
                void'(due_q.pop_front());
            end
        end
    end

endmodule

// File: src/spmv_vector_loader.sv
module spmv_vector_loader #(
    parameter logic [vec_loader_pkg::ADDR_W-1:0] HBM_BASE  = vec_loader_pkg::HBM_BASE_DEF,
    parameter logic [vec_loader_pkg::ADDR_W-1:0] HBM_SIZE  = vec_loader_pkg::HBM_SIZE_DEF,
    parameter logic [vec_loader_pkg::ADDR_W-1:0] BRAM_BASE = vec_loader_pkg::BRAM_BASE_DEF,
    parameter logic [vec_loader_pkg::ADDR_W-1:0] BRAM_SIZE = vec_loader_pkg::BRAM_SIZE_DEF
) (
    input  logic                                     pcie_aclk,
    input  logic                                     rst,
    // host request
    input  logic                                     req_valid,
    output logic                                     req_ready,
    input  vec_loader_pkg::op_e                      req_op,
    input  logic [vec_loader_pkg::ADDR_W-1:0]        req_addr,
    input  logic [vec_loader_pkg::HOST_DATA_W-1:0]   req_wdata,
    input  logic [vec_loader_pkg::HOST_STRB_W-1:0]   req_wstrb,
    // host response
    output logic                                     rsp_valid,
    input  logic                                     rsp_ready,
    output vec_loader_pkg::op_e                      rsp_op,
    output logic [vec_loader_pkg::HOST_DATA_W-1:0]   rsp_rdata,
    output logic                                     rsp_err,
    // hbm beat port
    output logic                                     hbm_cmd_valid,
    input  logic                                     hbm_cmd_ready,
    output logic                                     hbm_cmd_we,
    output logic [vec_loader_pkg::ADDR_W-1:0]        hbm_cmd_addr,
    output logic [vec_loader_pkg::HBM_DATA_W-1:0]    hbm_cmd_wdata,
    output logic [vec_loader_pkg::HBM_DATA_W/8-1:0]  hbm_cmd_wstrb,
    input  logic                                     hbm_rvalid,
    input  logic [vec_loader_pkg::HBM_DATA_W-1:0]    hbm_rdata,
    // bram beat port
    output logic                                     bram_cmd_valid,
    input  logic                                     bram_cmd_ready,
    output logic                                     bram_cmd_we,
    output logic [vec_loader_pkg::ADDR_W-1:0]        bram_cmd_addr,
    output logic [vec_loader_pkg::BRAM_DATA_W-1:0]   bram_cmd_wdata,
    output logic [vec_loader_pkg::BRAM_DATA_W/8-1:0] bram_cmd_wstrb,
    input  logic                                     bram_rvalid,
    input  logic [vec_loader_pkg::BRAM_DATA_W-1:0]   bram_rdata
);

    localparam int ADDR_W = vec_loader_pkg::ADDR_W;

    logic                                   hbm_launch;
    logic                                   bram_launch;
    logic                                   dec_start;
    vec_loader_pkg::op_e                    dec_op;
    vec_loader_pkg::target_e                dec_target;
    logic [ADDR_W-1:0]                      dec_addr;
    logic [vec_loader_pkg::HOST_DATA_W-1:0] dec_wdata;
    logic [vec_loader_pkg::HOST_STRB_W-1:0] dec_wstrb;
    logic                                   hbm_writes_done;
    logic                                   bram_writes_done;
    logic                                   txn_done;

    vec_addr_decoder #(
        .ADDR_W   (ADDR_W),
        .HBM_BASE (HBM_BASE),
        .HBM_SIZE (HBM_SIZE),
        .BRAM_BASE(BRAM_BASE),
        .BRAM_SIZE(BRAM_SIZE)
    ) decoder_i (
        .pcie_aclk, .rst,
        .req_valid, .req_ready, .req_op, .req_addr, .req_wdata, .req_wstrb,
        .hbm_launch, .bram_launch,
        .op(dec_op), .addr(dec_addr), .wdata(dec_wdata), .wstrb(dec_wstrb),
        .start(dec_start), .target(dec_target), .txn_done
    );

    vec_beat_splitter #(.BEAT_W(vec_loader_pkg::HBM_DATA_W), .ADDR_W(ADDR_W)) hbm_splitter_i (
        .pcie_aclk, .rst,
        .launch(hbm_launch), .op(dec_op), .addr(dec_addr), .wdata(dec_wdata), .wstrb(dec_wstrb),
        .cmd_valid(hbm_cmd_valid), .cmd_ready(hbm_cmd_ready), .cmd_we(hbm_cmd_we),
        .cmd_addr(hbm_cmd_addr), .cmd_wdata(hbm_cmd_wdata), .cmd_wstrb(hbm_cmd_wstrb),
        .writes_done(hbm_writes_done)
    );

    vec_beat_splitter #(.BEAT_W(vec_loader_pkg::BRAM_DATA_W), .ADDR_W(ADDR_W)) bram_splitter_i (
        .pcie_aclk, .rst,
        .launch(bram_launch), .op(dec_op), .addr(dec_addr), .wdata(dec_wdata), .wstrb(dec_wstrb),
        .cmd_valid(bram_cmd_valid), .cmd_ready(bram_cmd_ready), .cmd_we(bram_cmd_we),
        .cmd_addr(bram_cmd_addr), .cmd_wdata(bram_cmd_wdata), .cmd_wstrb(bram_cmd_wstrb),
        .writes_done(bram_writes_done)
    );

    vec_read_gather gather_i (
        .pcie_aclk, .rst,
        .start(dec_start), .target(dec_target), .op(dec_op),
        .hbm_rvalid, .hbm_rdata, .bram_rvalid, .bram_rdata,
        .hbm_writes_done, .bram_writes_done,
        .rsp_valid, .rsp_ready, .rsp_op, .rsp_rdata, .rsp_err,
        .txn_done
    );

endmodule

// File: src/vec_read_gather.sv
module vec_read_gather (
    input  logic                                   pcie_aclk,
    input  logic                                   rst,
    // from the decoder
    input  logic                                   start,
    input  vec_loader_pkg::target_e                target,
    input  vec_loader_pkg::op_e                    op,
    // read beats
    input  logic                                   hbm_rvalid,
    input  logic [vec_loader_pkg::HBM_DATA_W-1:0]  hbm_rdata,
    input  logic                                   bram_rvalid,
    input  logic [vec_loader_pkg::BRAM_DATA_W-1:0] bram_rdata,
    // write completion
    input  logic                                   hbm_writes_done,
    input  logic                                   bram_writes_done,
    // host response
    output logic                                   rsp_valid,
    input  logic                                   rsp_ready,
    output vec_loader_pkg::op_e                    rsp_op,
    output logic [vec_loader_pkg::HOST_DATA_W-1:0] rsp_rdata,
    output logic                                   rsp_err,
    output logic                                   txn_done
);

    localparam int HW        = vec_loader_pkg::HOST_DATA_W;
    localparam int HBM_W     = vec_loader_pkg::HBM_DATA_W;
    localparam int BRAM_W    = vec_loader_pkg::BRAM_DATA_W;
    localparam int HBM_BEATS = HW / HBM_W;
    localparam int BRAM_BEATS = HW / BRAM_W;
    localparam int MAX_BEATS = (HBM_BEATS > BRAM_BEATS) ? HBM_BEATS : BRAM_BEATS;
    localparam int CNT_W     = (MAX_BEATS > 1) ? $clog2(MAX_BEATS) : 1;

    vec_loader_pkg::gat_state_e state;
    vec_loader_pkg::target_e    tgt_r;
    logic [CNT_W-1:0]           cnt;       // read beats gathered so far
    logic                       hbm_wait;
    logic                       bram_wait;
    logic                       is_read;
    logic                       hbm_beat;
    logic                       bram_beat;
    logic                       last_beat;
    logic                       wr_done;

    assign hbm_wait  = (state == vec_loader_pkg::GAT_WAIT) && (tgt_r == vec_loader_pkg::TGT_HBM);
    assign bram_wait = (state == vec_loader_pkg::GAT_WAIT) && (tgt_r == vec_loader_pkg::TGT_BRAM);
    assign is_read   = (rsp_op == vec_loader_pkg::OP_READ);

    assign hbm_beat  = hbm_wait && is_read && hbm_rvalid;
    assign bram_beat = bram_wait && is_read && bram_rvalid;
    assign last_beat = (hbm_beat && cnt == CNT_W'(HBM_BEATS - 1))
                    || (bram_beat && cnt == CNT_W'(BRAM_BEATS - 1));
    assign wr_done   = !is_read && ((hbm_wait && hbm_writes_done)
                                 || (bram_wait && bram_writes_done));

    assign rsp_valid = (state == vec_loader_pkg::GAT_RESPOND);
    assign txn_done  = rsp_valid && rsp_ready;  // response handshake

    always_ff @(posedge pcie_aclk) begin
        if (rst) begin
            state <= vec_loader_pkg::GAT_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                vec_loader_pkg::GAT_IDLE: begin
                    cnt <= '0;
                    if (start) begin  // decode error answers right away
                        state <= (target == vec_loader_pkg::TGT_NONE) ?
                                 vec_loader_pkg::GAT_RESPOND : vec_loader_pkg::GAT_WAIT;
                    end
                end
                vec_loader_pkg::GAT_WAIT: begin
                    if (hbm_beat || bram_beat) cnt <= cnt + 1'b1;
                    if (last_beat || wr_done) state <= vec_loader_pkg::GAT_RESPOND;
                end
                vec_loader_pkg::GAT_RESPOND: if (txn_done) state <= vec_loader_pkg::GAT_IDLE;
                default: state <= vec_loader_pkg::GAT_IDLE;
            endcase
        end
    end

    // response payload, beats shift in from the top so beat 0 lands lowest
    always_ff @(posedge pcie_aclk) begin
        if (start) begin
            tgt_r     <= target;
            rsp_op    <= op;
            rsp_err   <= (target == vec_loader_pkg::TGT_NONE);
            rsp_rdata <= '0;  // stays zero for writes and errors
        end else if (hbm_beat) begin
            rsp_rdata <= {hbm_rdata, rsp_rdata[HW-1:HBM_W]};
        end else if (bram_beat) begin
            rsp_rdata <= {bram_rdata, rsp_rdata[HW-1:BRAM_W]};
        end
    end

    // read data only returns from the memory this read went to
    a_hbm_rvalid_sel: assert property (@(posedge pcie_aclk) disable iff (rst)
        hbm_rvalid |-> hbm_wait && is_read);
    a_bram_rvalid_sel: assert property (@(posedge pcie_aclk) disable iff (rst)
        bram_rvalid |-> bram_wait && is_read);

endmodule

// File: src/vec_beat_splitter.sv
module vec_beat_splitter #(
    parameter int BEAT_W = vec_loader_pkg::HBM_DATA_W,
    parameter int ADDR_W = vec_loader_pkg::ADDR_W
) (
    input  logic                                   pcie_aclk,
    input  logic                                   rst,
    // from the decoder
    input  logic                                   launch,
    input  vec_loader_pkg::op_e                    op,
    input  logic [ADDR_W-1:0]                      addr,
    input  logic [vec_loader_pkg::HOST_DATA_W-1:0] wdata,
    input  logic [vec_loader_pkg::HOST_STRB_W-1:0] wstrb,
    // memory beat port
    output logic                                   cmd_valid,
    input  logic                                   cmd_ready,
    output logic                                   cmd_we,
    output logic [ADDR_W-1:0]                      cmd_addr,
    output logic [BEAT_W-1:0]                      cmd_wdata,
    output logic [BEAT_W/8-1:0]                    cmd_wstrb,
    output logic                                   writes_done
);

    localparam int NBEATS = vec_loader_pkg::HOST_DATA_W / BEAT_W;  // beats per host word
    localparam int BEAT_B = BEAT_W / 8;                             // bytes per beat
    localparam int CNT_W  = (NBEATS > 1) ? $clog2(NBEATS) : 1;

    vec_loader_pkg::spl_state_e state;
    logic [CNT_W-1:0]           cnt;       // slice index k
    logic [ADDR_W-1:0]          beat_addr; // addr + k * BEAT_B
    logic                       fire;
    logic                       last;

    assign cmd_valid = (state == vec_loader_pkg::SPL_ISSUE);
    assign cmd_we    = (op == vec_loader_pkg::OP_WRITE);
    assign cmd_addr  = beat_addr;
    assign cmd_wdata = wdata[cnt*BEAT_W +: BEAT_W];  // lsb slice first
    assign cmd_wstrb = wstrb[cnt*BEAT_B +: BEAT_B];

    assign fire = cmd_valid && cmd_ready;
    assign last = (cnt == CNT_W'(NBEATS - 1));

    always_ff @(posedge pcie_aclk) begin
        if (rst) begin
            state       <= vec_loader_pkg::SPL_IDLE;
            cnt         <= '0;
            writes_done <= 1'b0;
        end else begin
            writes_done <= fire && last && cmd_we;  // cycle after last write accepted
            case (state)
                vec_loader_pkg::SPL_IDLE: begin
                    if (launch) begin
                        state <= vec_loader_pkg::SPL_ISSUE;
                        cnt   <= '0;
                    end
                end
                vec_loader_pkg::SPL_ISSUE: begin
                    if (fire) begin
                        if (last) state <= vec_loader_pkg::SPL_IDLE;
                        cnt <= cnt + 1'b1;  // wraps to 0 after last
                    end
                end
                default: state <= vec_loader_pkg::SPL_IDLE;
            endcase
        end
    end

    always_ff @(posedge pcie_aclk) begin
        if (launch) beat_addr <= addr;
        else if (fire) beat_addr <= beat_addr + ADDR_W'(BEAT_B);  // next slice
    end

    // a stalled beat is held unchanged until the memory takes it
    a_cmd_hold: assert property (@(posedge pcie_aclk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_addr) && $stable(cmd_we)
                                    && $stable(cmd_wdata) && $stable(cmd_wstrb));

endmodule

// File: src/vec_addr_decoder.sv
module vec_addr_decoder #(
    parameter int ADDR_W = vec_loader_pkg::ADDR_W,
    parameter logic [ADDR_W-1:0] HBM_BASE  = vec_loader_pkg::HBM_BASE_DEF,
    parameter logic [ADDR_W-1:0] HBM_SIZE  = vec_loader_pkg::HBM_SIZE_DEF,
    parameter logic [ADDR_W-1:0] BRAM_BASE = vec_loader_pkg::BRAM_BASE_DEF,
    parameter logic [ADDR_W-1:0] BRAM_SIZE = vec_loader_pkg::BRAM_SIZE_DEF
) (
    input  logic                                   pcie_aclk,
    input  logic                                   rst,
    // host request
    input  logic                                   req_valid,
    output logic                                   req_ready,
    input  vec_loader_pkg::op_e                    req_op,
    input  logic [ADDR_W-1:0]                      req_addr,
    input  logic [vec_loader_pkg::HOST_DATA_W-1:0] req_wdata,
    input  logic [vec_loader_pkg::HOST_STRB_W-1:0] req_wstrb,
    // held request towards the splitters
    output logic                                   hbm_launch,
    output logic                                   bram_launch,
    output vec_loader_pkg::op_e                    op,
    output logic [ADDR_W-1:0]                      addr,
    output logic [vec_loader_pkg::HOST_DATA_W-1:0] wdata,
    output logic [vec_loader_pkg::HOST_STRB_W-1:0] wstrb,
    // towards the gather
    output logic                                   start,
    output vec_loader_pkg::target_e                target,
    input  logic                                   txn_done
);

    localparam int OFS_W = $clog2(vec_loader_pkg::HOST_STRB_W);  // byte offset bits in a word

    vec_loader_pkg::dec_state_e state;
    vec_loader_pkg::target_e    target_nxt;
    logic                       accept;
    logic                       hbm_hit;
    logic                       bram_hit;

    assign req_ready = (state == vec_loader_pkg::DEC_IDLE);  // one request in flight
    assign accept    = req_valid && req_ready;

    // mask off the window offset and compare with the base
    assign hbm_hit  = (req_addr & ~(HBM_SIZE - 1'b1)) == HBM_BASE;
    assign bram_hit = (req_addr & ~(BRAM_SIZE - 1'b1)) == BRAM_BASE;

    assign target_nxt = hbm_hit  ? vec_loader_pkg::TGT_HBM  :
                        bram_hit ? vec_loader_pkg::TGT_BRAM : vec_loader_pkg::TGT_NONE;

    always_ff @(posedge pcie_aclk) begin
        if (rst) begin
            state       <= vec_loader_pkg::DEC_IDLE;
            start       <= 1'b0;
            hbm_launch  <= 1'b0;
            bram_launch <= 1'b0;
        end else begin
            start       <= accept;  // single-cycle strobes
            hbm_launch  <= accept && (target_nxt == vec_loader_pkg::TGT_HBM);
            bram_launch <= accept && (target_nxt == vec_loader_pkg::TGT_BRAM);
            case (state)
                vec_loader_pkg::DEC_IDLE: if (accept) state <= vec_loader_pkg::DEC_BUSY;
                vec_loader_pkg::DEC_BUSY: if (txn_done) state <= vec_loader_pkg::DEC_IDLE;
                default: state <= vec_loader_pkg::DEC_IDLE;
            endcase
        end
    end

    // request fields, held until the response handshake
    always_ff @(posedge pcie_aclk) begin
        if (accept) begin
            op     <= req_op;
            addr   <= req_addr;
            wdata  <= req_wdata;
            wstrb  <= req_wstrb;
            target <= target_nxt;
        end
    end

    // host words are whole 64-byte lines
    a_req_aligned: assert property (@(posedge pcie_aclk) disable iff (rst)
        accept |-> req_addr[OFS_W-1:0] == '0);

endmodule

// File: src/vec_loader_pkg.sv
package vec_loader_pkg;

    parameter int HOST_DATA_W = 512;  // one host word
    parameter int HBM_DATA_W  = 256;  // hbm beat
    parameter int BRAM_DATA_W = 64;   // bram beat
    parameter int ADDR_W      = 48;
    parameter int HOST_STRB_W = HOST_DATA_W / 8;  // byte strobes, 64

    // address map, each window naturally aligned to its size
    parameter logic [ADDR_W-1:0] HBM_BASE_DEF  = 48'h0000_0000_0000;
    parameter logic [ADDR_W-1:0] HBM_SIZE_DEF  = 48'h0000_0010_0000;  // 1 MiB of X vector
    parameter logic [ADDR_W-1:0] BRAM_BASE_DEF = 48'h0000_0020_0000;
    parameter logic [ADDR_W-1:0] BRAM_SIZE_DEF = 48'h0000_0001_0000;  // 64 KiB of Y vector

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } op_e;

    typedef enum logic [1:0] {
        TGT_HBM,
        TGT_BRAM,
        TGT_NONE  // decode error
    } target_e;

    typedef enum logic {DEC_IDLE, DEC_BUSY} dec_state_e;

    typedef enum logic {SPL_IDLE, SPL_ISSUE} spl_state_e;

    typedef enum logic [1:0] {GAT_IDLE, GAT_WAIT, GAT_RESPOND} gat_state_e;

endpackage
